//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tbImu
FILELIST  := list.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

//--- common/imu_params.svh
`ifndef IMU_PARAMS_SVH
`define IMU_PARAMS_SVH

//////////////////////////////
// MPU-6050 device
//////////////////////////////
`define MPU_ADDR       7'h68   // AD0 tied low

`define REG_SMPLRT     8'h19   // Sample rate divider
`define REG_CONFIG     8'h1A   // FSYNC and low-pass filter
`define REG_GYRO_CFG   8'h1B
`define REG_ACCEL_CFG  8'h1C
`define REG_PWR_MGMT   8'h6B
`define REG_ACCEL_XH   8'h3B   // Start of the sample burst

`define BURST_LEN      14      // Six axes plus temperature

// Clocks per quarter SCL period
`define I2C_QUARTER    4

//////////////////////////////
// AXI4-Lite register map
//////////////////////////////
`define AXI_AW         6
`define OFS_CTRL       6'h00
`define OFS_CFG        6'h04
`define OFS_STATUS     6'h08
`define OFS_DATA0      6'h10
`define OFS_DATA1      6'h14
`define OFS_DATA2      6'h18

`endif

//--- common/imu_pkg.sv
package imuPkg;

    typedef enum logic {
        opWrite,
        opRead
    } i2cOp_t;

    // One byte transfer for the I2C master
    typedef struct packed {
        i2cOp_t     op;
        logic       withStart;   // Start or repeated start first
        logic       withStop;    // Stop after the ACK bit
        logic       masterNack;  // Last byte of a read
        logic [7:0] data;
    } i2cCmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       ackErr;      // Written byte not acknowledged
    } i2cRsp_t;

    typedef struct packed {
        logic [7:0] sampleDiv;
        logic [2:0] dlpf;
        logic [1:0] gyroFs;
        logic [1:0] accelFs;
    } imuCfg_t;

    // Burst order, acX in the top bits
    typedef struct packed {
        logic signed [15:0] acX;
        logic signed [15:0] acY;
        logic signed [15:0] acZ;
        logic signed [15:0] gyX;
        logic signed [15:0] gyY;
        logic signed [15:0] gyZ;
    } imuSample_t;

    typedef enum logic [3:0] {
        sIdleReset,
        sCfgAddr,
        sCfgReg,
        sCfgData,
        sReady,
        sRdAddrW,
        sRdReg,
        sRdAddrR,
        sRdByte,
        sError
    } seqState_t;

endpackage

//--- dv/mpu_model.sv
`timescale 1ns/1ps
`include "imu_params.svh"

module mpuModel (
    input  logic clk,
    input  logic rst,
    input  logic scl_i,
    input  logic sda_i,        // Resolved line value
    input  logic ackEnable_i,
    output logic pull_o        // High pulls SDA low
);

    logic [7:0] regs [0:127];
    logic       sclQ;
    logic       sdaQ;
    logic       listen;        // Between start and stop
    logic       active;        // Addressed in this transfer
    logic       inAddr;        // Next byte is the address byte
    logic       rw;
    logic       firstData;     // Next written byte sets the pointer
    logic       sending;
    logic       masterAck;
    logic [3:0] bitCnt;        // SCL high pulses seen in this byte
    logic [7:0] shiftIn;
    logic [7:0] txShift;
    logic [6:0] ptr;
    integer     seed;

    always @(posedge clk) begin
        sclQ <= scl_i;
        sdaQ <= sda_i;
        if (rst) begin
            seed = 96014;
            for (int i = 0; i < 128; i++) begin
                if (i >= 'h3B && i <= 'h48) begin
                    regs[7'(i)] <= 8'($random(seed));   // Sensor sample bytes
                end else begin
                    regs[7'(i)] <= 8'(i) ^ 8'h96;
                end
            end
            listen  <= 1'b0;
            active  <= 1'b0;
            inAddr  <= 1'b0;
            sending <= 1'b0;
            pull_o  <= 1'b0;
            bitCnt  <= 4'd0;
            ptr     <= 7'd0;
        end else if (scl_i && sclQ && sdaQ && !sda_i) begin
            listen  <= 1'b1;                         // Start or repeated start
            inAddr  <= 1'b1;
            active  <= 1'b0;
            sending <= 1'b0;
            pull_o  <= 1'b0;
            bitCnt  <= 4'd0;
        end else if (scl_i && sclQ && !sdaQ && sda_i) begin
            listen  <= 1'b0;                         // Stop
            active  <= 1'b0;
            sending <= 1'b0;
            pull_o  <= 1'b0;
        end else if (listen && scl_i && !sclQ) begin
            if (bitCnt < 4'd8) begin
                shiftIn <= {shiftIn[6:0], sda_i};
            end else if (bitCnt == 4'd8) begin
                masterAck <= !sda_i;
            end
            bitCnt <= bitCnt + 4'd1;
        end else if (listen && !scl_i && sclQ) begin
            if (bitCnt >= 4'd1 && bitCnt <= 4'd7) begin
                if (sending) begin
                    pull_o  <= !txShift[6];          // Next bit while SCL low
                    txShift <= {txShift[6:0], 1'b0};
                end
            end else if (bitCnt == 4'd8) begin
                pull_o <= 1'b0;
                if (inAddr) begin
                    inAddr <= 1'b0;
                    if (shiftIn[7:1] == `MPU_ADDR && ackEnable_i) begin
                        active    <= 1'b1;
                        rw        <= shiftIn[0];
                        firstData <= 1'b1;
                        pull_o    <= 1'b1;
                    end
                end else if (active && !rw) begin
                    pull_o <= 1'b1;
                    if (firstData) begin
                        ptr       <= shiftIn[6:0];
                        firstData <= 1'b0;
                    end else begin
                        regs[ptr] <= shiftIn;
                        ptr       <= ptr + 7'd1;
                    end
                end
            end else if (bitCnt == 4'd9) begin
                bitCnt <= 4'd0;
                if (active && rw && (!sending || masterAck)) begin
                    txShift <= regs[ptr];
                    pull_o  <= !regs[ptr][7];
                    ptr     <= ptr + 7'd1;
                    sending <= 1'b1;
                end else begin
                    pull_o <= 1'b0;
                    if (sending) begin
                        sending <= 1'b0;             // Master NACK ends the read
                        active  <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- dv/tb_imu.sv
`timescale 1ns/1ps
`include "imu_params.svh"

module tbImu;

    typedef enum logic [2:0] {
        actWrite,      // AXI write of wval
        actRead,       // AXI read compared with exp
        actWait,       // Poll STATUS until busy drops
        actModel,      // Sensor register at ofs against exp
        actSample,     // DATA word against the sensor bytes
        actAckEn       // Sensor acknowledge on or off
    } action_t;

    typedef struct packed {
        action_t     act;
        logic [7:0]  ofs;
        logic [31:0] wval;
        logic [31:0] exp;
    } row_t;

    localparam logic [7:0] ofsCtrl   = 8'(`OFS_CTRL);
    localparam logic [7:0] ofsCfg    = 8'(`OFS_CFG);
    localparam logic [7:0] ofsStatus = 8'(`OFS_STATUS);
    localparam logic [7:0] ofsData0  = 8'(`OFS_DATA0);
    localparam logic [7:0] ofsData1  = 8'(`OFS_DATA1);
    localparam logic [7:0] ofsData2  = 8'(`OFS_DATA2);

    logic        clk = 1'b0;
    logic        rst;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic [5:0]  awaddr, araddr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [31:0] rdata;
    logic        scl, sdaOe, mpuPull, sda, ackEnable;
    row_t        rows[$];
    int          cycles = 0;
    int          cycleLimit = 0;

    assign sda = !(sdaOe || mpuPull);                 // Open-drain wired AND

    always #2 clk = ~clk;

    imuTop u_dut (
        .clk(clk), .rst(rst),
        .awvalid_i(awvalid), .awaddr_i(awaddr), .wvalid_i(wvalid), .wdata_i(wdata),
        .wstrb_i(wstrb), .bready_i(bready), .arvalid_i(arvalid), .araddr_i(araddr),
        .rready_i(rready), .awready_o(awready), .wready_o(wready), .bvalid_o(bvalid),
        .bresp_o(bresp), .arready_o(arready), .rvalid_o(rvalid), .rdata_o(rdata),
        .rresp_o(rresp), .sdaI_i(sda), .sclO_o(scl), .sdaOeO_o(sdaOe)
    );

    mpuModel u_mpu (
        .clk(clk), .rst(rst), .scl_i(scl), .sda_i(sda),
        .ackEnable_i(ackEnable), .pull_o(mpuPull)
    );

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR @ %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic axiWrite(input logic [5:0] addr, input logic [31:0] data);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hF;
        @(posedge clk);
        while (!awready) @(posedge clk);
        checkEq("wready with awready", {31'd0, wready}, 32'd1);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge clk);
        while (!bvalid) @(posedge clk);                // bready held high
        checkEq("bresp", {30'd0, bresp}, 32'd0);       // OKAY
    endtask

    task automatic axiRead(input logic [5:0] addr, output logic [31:0] data);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        checkEq("rresp", {30'd0, rresp}, 32'd0);
        data = rdata;
    endtask

    task automatic waitIdle();
        logic [31:0] st;
        axiRead(`OFS_STATUS, st);
        while (st[0]) axiRead(`OFS_STATUS, st);
    endtask

    // Big-endian axis word from two sensor registers
    function automatic logic [15:0] axisWord(input logic [6:0] a);
        return {u_mpu.regs[a], u_mpu.regs[a + 7'd1]};
    endfunction

    function automatic logic [31:0] sampleWord(input logic [7:0] ofs);
        case (ofs[5:0])
            `OFS_DATA0: return {axisWord(7'h3D), axisWord(7'h3B)};   // acY, acX
            `OFS_DATA1: return {axisWord(7'h43), axisWord(7'h3F)};   // gyX, acZ
            default:    return {axisWord(7'h47), axisWord(7'h45)};   // gyZ, gyY
        endcase
    endfunction

    function automatic void addRow(input action_t act, input logic [7:0] ofs,
                                   input logic [31:0] wval, input logic [31:0] exp);
        rows.push_back(row_t'{act, ofs, wval, exp});
    endfunction

    task automatic addSampleRows();
        addRow(actSample, ofsData0, 32'h0, 32'h0);
        addRow(actSample, ofsData1, 32'h0, 32'h0);
        addRow(actSample, ofsData2, 32'h0, 32'h0);
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////
    task automatic buildTable();
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0001);   // Busy with init
        addRow(actRead,  ofsCfg,    32'h0, 32'h0000_0100);   // dlpf 1, rest 0
        addRow(actWait,  8'h00,     32'h0, 32'h0);
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0002);
        addRow(actModel, 8'h19,     32'h0, 32'h0000_0000);
        addRow(actModel, 8'h1A,     32'h0, 32'h0000_0001);
        addRow(actModel, 8'h1B,     32'h0, 32'h0000_0000);
        addRow(actModel, 8'h1C,     32'h0, 32'h0000_0000);
        addRow(actModel, 8'h6B,     32'h0, 32'h0000_0000);
        addRow(actWrite, ofsCtrl,   32'h1, 32'h0);           // Trigger
        addRow(actWait,  8'h00,     32'h0, 32'h0);
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0102);
        addSampleRows();
        // div 7, dlpf 3, gyro range 2, accel range 1
        addRow(actWrite, ofsCfg,    32'h0001_2307, 32'h0);
        addRow(actRead,  ofsCfg,    32'h0, 32'h0001_2307);
        addRow(actWrite, ofsCtrl,   32'h2, 32'h0);           // Reinit
        addRow(actWait,  8'h00,     32'h0, 32'h0);
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0102);
        addRow(actModel, 8'h19,     32'h0, 32'h0000_0007);
        addRow(actModel, 8'h1A,     32'h0, 32'h0000_0003);
        addRow(actModel, 8'h1B,     32'h0, 32'h0000_0010);   // 2 << 3
        addRow(actModel, 8'h1C,     32'h0, 32'h0000_0008);   // 1 << 3
        addRow(actModel, 8'h6B,     32'h0, 32'h0000_0000);
        addRow(actWrite, ofsCtrl,   32'h1, 32'h0);
        addRow(actWait,  8'h00,     32'h0, 32'h0);
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0202);
        addSampleRows();
        // Sensor stops acknowledging
        addRow(actAckEn, 8'h00,     32'h0, 32'h0);
        addRow(actWrite, ofsCtrl,   32'h1, 32'h0);
        addRow(actWait,  8'h00,     32'h0, 32'h0);
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0204);   // Error, count kept
        addSampleRows();
        addRow(actAckEn, 8'h00,     32'h1, 32'h0);           // Sensor answers again
        addRow(actWrite, ofsCtrl,   32'h1, 32'h0);           // Ignored in error
        addRow(actWait,  8'h00,     32'h0, 32'h0);
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0204);
        addRow(actWrite, ofsCtrl,   32'h2, 32'h0);
        addRow(actWait,  8'h00,     32'h0, 32'h0);
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0202);
        addRow(actWrite, ofsCtrl,   32'h1, 32'h0);
        addRow(actWait,  8'h00,     32'h0, 32'h0);
        addRow(actRead,  ofsStatus, 32'h0, 32'h0000_0302);
        addSampleRows();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout: stopped waiting for the DUT after %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] got;
        int          waits;
        rst       = 1'b1;
        awvalid   = 1'b0;
        awaddr    = 6'd0;
        wvalid    = 1'b0;
        wdata     = 32'd0;
        wstrb     = 4'd0;
        bready    = 1'b1;
        arvalid   = 1'b0;
        araddr    = 6'd0;
        rready    = 1'b1;
        ackEnable = 1'b1;
        buildTable();
        waits = 0;
        foreach (rows[i]) begin
            if (rows[i].act == actWait) waits++;
        end
        cycleLimit = 2000 * waits + 5000;          // Rows that wait on the I2C bus

        repeat (16) @(posedge clk);
        checkEq("sclO after reset", {31'd0, scl}, 32'd1);
        checkEq("sdaOe after reset", {31'd0, sdaOe}, 32'd0);
        rst <= 1'b0;
        @(posedge clk);

        foreach (rows[i]) begin
            case (rows[i].act)
                actWrite: axiWrite(rows[i].ofs[5:0], rows[i].wval);
                actRead: begin
                    axiRead(rows[i].ofs[5:0], got);
                    checkEq($sformatf("row %0d offset 0x%02h", i, rows[i].ofs),
                            got, rows[i].exp);
                end
                actWait: waitIdle();
                actModel: checkEq($sformatf("row %0d sensor reg 0x%02h", i, rows[i].ofs),
                                  {24'd0, u_mpu.regs[rows[i].ofs[6:0]]}, rows[i].exp);
                actSample: begin
                    axiRead(rows[i].ofs[5:0], got);
                    checkEq($sformatf("row %0d data 0x%02h", i, rows[i].ofs),
                            got, sampleWord(rows[i].ofs));
                end
                default: begin
                    ackEnable <= rows[i].wval[0];
                    @(posedge clk);
                end
            endcase
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- hw/imu_regs.sv
`timescale 1ns/1ps
`include "imu_params.svh"

module imuRegs
    import imuPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               awvalid_i,
    input  logic [`AXI_AW-1:0] awaddr_i,
    input  logic               wvalid_i,
    input  logic [31:0]        wdata_i,
    input  logic [3:0]         wstrb_i,
    input  logic               bready_i,
    input  logic               arvalid_i,
    input  logic [`AXI_AW-1:0] araddr_i,
    input  logic               rready_i,
    output logic               awready_o,
    output logic               wready_o,
    output logic               bvalid_o,
    output logic [1:0]         bresp_o,
    output logic               arready_o,
    output logic               rvalid_o,
    output logic [31:0]        rdata_o,
    output logic [1:0]         rresp_o,
    input  logic               busy_i,
    input  logic               ready_i,
    input  logic               error_i,
    input  imuSample_t         sample_i,
    input  logic               sampleStrobe_i,
    output imuCfg_t            cfg_o,
    output logic               trigger_o,
    output logic               reinit_o
);

    logic        idle;
    logic        wrEn;
    logic        rdEn;
    logic        ctrlWr;
    logic [7:0]  sampleCnt;
    logic [31:0] rdMux;

    assign idle   = !bvalid_o && !rvalid_o;          // Nothing waiting on the master
    assign wrEn   = idle && awvalid_i && wvalid_i;
    assign rdEn   = idle && arvalid_i && !wrEn;      // Write wins a tie
    assign ctrlWr = wrEn && (awaddr_i == `OFS_CTRL) && wstrb_i[0];

    assign awready_o = wrEn;
    assign wready_o  = wrEn;
    assign arready_o = rdEn;
    assign bresp_o   = 2'b00;                        // OKAY
    assign rresp_o   = 2'b00;

    ///////////////////////////////
    // Write channel
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_o  <= 1'b0;
            trigger_o <= 1'b0;
            reinit_o  <= 1'b0;
            cfg_o     <= '{sampleDiv: 8'h00, dlpf: 3'd1, gyroFs: 2'd0, accelFs: 2'd0};
        end else begin
            trigger_o <= ctrlWr && wdata_i[0];       // One-cycle pulses
            reinit_o  <= ctrlWr && wdata_i[1];
            if (wrEn) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (wrEn && awaddr_i == `OFS_CFG) begin
                if (wstrb_i[0]) cfg_o.sampleDiv <= wdata_i[7:0];
                if (wstrb_i[1]) begin
                    cfg_o.dlpf   <= wdata_i[10:8];
                    cfg_o.gyroFs <= wdata_i[13:12];
                end
                if (wstrb_i[2]) cfg_o.accelFs <= wdata_i[17:16];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sampleCnt <= 8'd0;
        end else if (sampleStrobe_i) begin
            sampleCnt <= sampleCnt + 8'd1;            // Wraps at 256
        end
    end

    ///////////////////////////////
    // Read channel
    ///////////////////////////////
    always_comb begin
        case (araddr_i)
            `OFS_CFG:    rdMux = {14'd0, cfg_o.accelFs, 2'd0, cfg_o.gyroFs,
                                  1'b0, cfg_o.dlpf, cfg_o.sampleDiv};
            `OFS_STATUS: rdMux = {16'd0, sampleCnt, 5'd0, error_i, ready_i, busy_i};
            `OFS_DATA0:  rdMux = {sample_i.acY, sample_i.acX};
            `OFS_DATA1:  rdMux = {sample_i.gyX, sample_i.acZ};
            `OFS_DATA2:  rdMux = {sample_i.gyZ, sample_i.gyY};
            default:     rdMux = 32'd0;              // CTRL and holes
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_o <= 1'b0;
        end else if (rdEn) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdata_o <= rdMux;
        end
    end

    bHeld: assert property (@(posedge clk) disable iff (rst)
        bvalid_o && !bready_i |=> bvalid_o);
    rHeld: assert property (@(posedge clk) disable iff (rst)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule

//--- hw/imu_sequencer.sv
`timescale 1ns/1ps
`include "imu_params.svh"

module imuSequencer
    import imuPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  imuCfg_t    cfg_i,
    input  logic       trigger_i,
    input  logic       reinit_i,
    input  logic       cmdReady_i,
    input  logic       rspValid_i,
    input  i2cRsp_t    rsp_i,
    output logic       cmdValid_o,
    output i2cCmd_t    cmd_o,
    output logic       busy_o,
    output logic       ready_o,
    output logic       error_o,
    output imuSample_t sample_o,
    output logic       sampleStrobe_o
);

    localparam logic [3:0] LAST_BYTE = 4'(`BURST_LEN - 1);

    seqState_t   state;
    logic [2:0]  step;          // Config register index
    logic [3:0]  byteIdx;
    logic        waitRsp;       // Command out, result pending
    logic        reinitPend;
    logic        sending;
    logic        lastByte;
    logic [7:0]  cfgReg;
    logic [7:0]  cfgVal;
    logic [87:0] work;          // Burst bytes so far, temperature dropped

    assign sending    = state inside {sCfgAddr, sCfgReg, sCfgData,
                                      sRdAddrW, sRdReg, sRdAddrR, sRdByte};
    assign cmdValid_o = sending && !waitRsp && !reinitPend && !reinit_i;
    assign lastByte   = (byteIdx == LAST_BYTE);
    assign busy_o     = !(state inside {sReady, sError});
    assign ready_o    = state inside {sReady, sRdAddrW, sRdReg, sRdAddrR, sRdByte};
    assign error_o    = (state == sError);

    always_comb begin
        case (step)
            3'd0:    begin cfgReg = `REG_SMPLRT;    cfgVal = cfg_i.sampleDiv;             end
            3'd1:    begin cfgReg = `REG_CONFIG;    cfgVal = {5'd0, cfg_i.dlpf};          end
            3'd2:    begin cfgReg = `REG_GYRO_CFG;  cfgVal = {3'd0, cfg_i.gyroFs, 3'd0};  end
            3'd3:    begin cfgReg = `REG_ACCEL_CFG; cfgVal = {3'd0, cfg_i.accelFs, 3'd0}; end
            default: begin cfgReg = `REG_PWR_MGMT;  cfgVal = 8'h00;                       end
        endcase
    end

    always_comb begin
        cmd_o    = '0;
        cmd_o.op = opWrite;
        case (state)
            sCfgAddr, sRdAddrW: begin
                cmd_o.withStart = 1'b1;
                cmd_o.data      = {`MPU_ADDR, 1'b0};
            end
            sCfgReg: cmd_o.data = cfgReg;
            sCfgData: begin
                cmd_o.data     = cfgVal;
                cmd_o.withStop = 1'b1;
            end
            sRdReg: cmd_o.data = `REG_ACCEL_XH;
            sRdAddrR: begin
                cmd_o.withStart = 1'b1;                   // Repeated start
                cmd_o.data      = {`MPU_ADDR, 1'b1};
            end
            sRdByte: begin
                cmd_o.op         = opRead;
                cmd_o.masterNack = lastByte;
                cmd_o.withStop   = lastByte;
            end
            default: ;
        endcase
    end

    ///////////////////////////////
    // Main FSM
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= sIdleReset;
            step           <= 3'd0;
            byteIdx        <= 4'd0;
            waitRsp        <= 1'b0;
            reinitPend     <= 1'b0;
            sampleStrobe_o <= 1'b0;
            sample_o       <= '0;
        end else begin
            sampleStrobe_o <= 1'b0;
            if (reinit_i) reinitPend <= 1'b1;
            if (waitRsp) begin
                if (rspValid_i) waitRsp <= 1'b0;
            end else if (cmdValid_o && cmdReady_i) begin
                waitRsp <= 1'b1;
            end

            if ((reinit_i || reinitPend) && (!waitRsp || rspValid_i)) begin
                state      <= sIdleReset;                 // Byte on the wire has ended
                reinitPend <= 1'b0;
            end else if (rspValid_i && rsp_i.ackErr) begin
                state <= sError;                          // Sticky until reinit
            end else begin
                case (state)
                    sIdleReset: begin
                        step  <= 3'd0;
                        state <= sCfgAddr;
                    end
                    sCfgAddr: if (rspValid_i) state <= sCfgReg;
                    sCfgReg:  if (rspValid_i) state <= sCfgData;
                    sCfgData: if (rspValid_i) begin
                        step  <= step + 3'd1;
                        state <= (step == 3'd4) ? sReady : sCfgAddr;
                    end
                    sReady:   if (trigger_i) state <= sRdAddrW;
                    sRdAddrW: if (rspValid_i) state <= sRdReg;
                    sRdReg:   if (rspValid_i) state <= sRdAddrR;
                    sRdAddrR: if (rspValid_i) begin
                        byteIdx <= 4'd0;
                        state   <= sRdByte;
                    end
                    sRdByte:  if (rspValid_i) begin
                        byteIdx <= byteIdx + 4'd1;
                        if (byteIdx != 4'd6 && byteIdx != 4'd7) begin
                            work <= {work[79:0], rsp_i.data};     // High byte first
                        end
                        if (lastByte) begin
                            sample_o       <= {work, rsp_i.data};
                            sampleStrobe_o <= 1'b1;
                            state          <= sReady;
                        end
                    end
                    default: ;                            // sError holds
                endcase
            end
        end
    end

    noCmdInError: assert property (@(posedge clk) disable iff (rst)
        (state == sError) |-> !cmdValid_o);

endmodule

//--- hw/imu_top.sv
`timescale 1ns/1ps
`include "imu_params.svh"

module imuTop
    import imuPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               awvalid_i,
    input  logic [`AXI_AW-1:0] awaddr_i,
    input  logic               wvalid_i,
    input  logic [31:0]        wdata_i,
    input  logic [3:0]         wstrb_i,
    input  logic               bready_i,
    input  logic               arvalid_i,
    input  logic [`AXI_AW-1:0] araddr_i,
    input  logic               rready_i,
    output logic               awready_o,
    output logic               wready_o,
    output logic               bvalid_o,
    output logic [1:0]         bresp_o,
    output logic               arready_o,
    output logic               rvalid_o,
    output logic [31:0]        rdata_o,
    output logic [1:0]         rresp_o,
    input  logic               sdaI_i,
    output logic               sclO_o,
    output logic               sdaOeO_o
);

    imuCfg_t    cfg;
    imuSample_t sample;
    logic       trigger;
    logic       reinit;
    logic       busy;
    logic       ready;
    logic       error;
    logic       sampleStrobe;
    logic       cmdValid;
    logic       cmdReady;
    i2cCmd_t    cmd;
    logic       rspValid;
    i2cRsp_t    rsp;

    imuRegs u_regs (
        .clk            (clk),
        .rst            (rst),
        .awvalid_i      (awvalid_i),
        .awaddr_i       (awaddr_i),
        .wvalid_i       (wvalid_i),
        .wdata_i        (wdata_i),
        .wstrb_i        (wstrb_i),
        .bready_i       (bready_i),
        .arvalid_i      (arvalid_i),
        .araddr_i       (araddr_i),
        .rready_i       (rready_i),
        .awready_o      (awready_o),
        .wready_o       (wready_o),
        .bvalid_o       (bvalid_o),
        .bresp_o        (bresp_o),
        .arready_o      (arready_o),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o),
        .rresp_o        (rresp_o),
        .busy_i         (busy),
        .ready_i        (ready),
        .error_i        (error),
        .sample_i       (sample),
        .sampleStrobe_i (sampleStrobe),
        .cfg_o          (cfg),
        .trigger_o      (trigger),
        .reinit_o       (reinit)
    );

    imuSequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .cfg_i          (cfg),
        .trigger_i      (trigger),
        .reinit_i       (reinit),
        .cmdReady_i     (cmdReady),
        .rspValid_i     (rspValid),
        .rsp_i          (rsp),
        .cmdValid_o     (cmdValid),
        .cmd_o          (cmd),
        .busy_o         (busy),
        .ready_o        (ready),
        .error_o        (error),
        .sample_o       (sample),
        .sampleStrobe_o (sampleStrobe)
    );

    i2cByteMaster u_i2c (
        .clk        (clk),
        .rst        (rst),
        .cmdValid_i (cmdValid),
        .cmd_i      (cmd),
        .sdaI_i     (sdaI_i),
        .cmdReady_o (cmdReady),
        .rspValid_o (rspValid),
        .rsp_o      (rsp),
        .sclO_o     (sclO_o),
        .sdaOeO_o   (sdaOeO_o)
    );

endmodule

//--- i2c/i2c_byte_master.sv
`timescale 1ns/1ps
`include "imu_params.svh"

module i2cByteMaster
    import imuPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cmdValid_i,
    input  i2cCmd_t cmd_i,
    input  logic    sdaI_i,
    output logic    cmdReady_o,
    output logic    rspValid_o,
    output i2cRsp_t rsp_o,
    output logic    sclO_o,
    output logic    sdaOeO_o
);

    typedef enum logic [2:0] {
        pIdle,
        pStart,
        pBit,
        pAck,
        pStop
    } phase_t;

    localparam logic [7:0] QLAST = 8'(`I2C_QUARTER - 1);

    phase_t     phase;
    logic [1:0] quarter;
    logic [7:0] qCnt;
    logic       qTick;
    logic [2:0] bitIdx;
    logic       sclHold;       // SCL level between commands
    i2cCmd_t    cur;
    logic [7:0] shift;
    logic       midQ;

    assign qTick      = (qCnt == QLAST);
    assign midQ       = quarter[0] ^ quarter[1];     // SCL high in quarters 1 and 2
    assign cmdReady_o = (phase == pIdle);

    ///////////////////////////////
    // Phase and quarter sequencing
    ///////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            phase      <= pIdle;
            quarter    <= 2'd0;
            qCnt       <= 8'd0;
            bitIdx     <= 3'd0;
            sclHold    <= 1'b1;
            rspValid_o <= 1'b0;
        end else begin
            rspValid_o <= 1'b0;
            if (phase == pIdle) begin
                qCnt    <= 8'd0;
                quarter <= 2'd0;
                bitIdx  <= 3'd0;
                if (cmdValid_i) begin
                    phase <= cmd_i.withStart ? pStart : pBit;
                end
            end else begin
                qCnt <= qTick ? 8'd0 : qCnt + 8'd1;
                if (qTick) begin
                    quarter <= quarter + 2'd1;
                    if (quarter == 2'd3) begin
                        case (phase)
                            pStart: phase <= pBit;
                            pBit: begin
                                bitIdx <= bitIdx + 3'd1;
                                if (bitIdx == 3'd7) phase <= pAck;
                            end
                            pAck: begin
                                if (cur.withStop) begin
                                    phase <= pStop;
                                end else begin
                                    phase      <= pIdle;  // SCL parked low
                                    rspValid_o <= 1'b1;
                                    sclHold    <= 1'b0;
                                end
                            end
                            default: begin
                                phase      <= pIdle;      // Bus free again
                                rspValid_o <= 1'b1;
                                sclHold    <= 1'b1;
                            end
                        endcase
                    end
                end
            end
        end
    end

    // Data shifting and sampling
    always_ff @(posedge clk) begin
        if (cmdReady_o && cmdValid_i) begin
            cur   <= cmd_i;
            shift <= cmd_i.data;
        end else if (qTick && quarter == 2'd3 && phase == pBit) begin
            shift <= {shift[6:0], 1'b0};                  // Next bit while SCL low
        end
        if (qTick && quarter == 2'd2 && phase == pBit) begin
            rsp_o.data <= {rsp_o.data[6:0], sdaI_i};      // MSB first
        end
        if (qTick && quarter == 2'd2 && phase == pAck) begin
            rsp_o.ackErr <= sdaI_i && (cur.op == opWrite);
        end
    end

    always_comb begin
        sclO_o   = sclHold;
        sdaOeO_o = 1'b0;
        case (phase)
            pStart: begin
                sclO_o   = midQ;
                sdaOeO_o = quarter[1];                    // SDA falls with SCL high
            end
            pBit: begin
                sclO_o   = midQ;
                sdaOeO_o = (cur.op == opWrite) && !shift[7];
            end
            pAck: begin
                sclO_o   = midQ;
                sdaOeO_o = (cur.op == opRead) && !cur.masterNack;
            end
            pStop: begin
                sclO_o   = (quarter != 2'd0);
                sdaOeO_o = !quarter[1];                   // SDA rises with SCL high
            end
            default: ;
        endcase
    end

    sdaStable: assert property (@(posedge clk) disable iff (rst)
        sclO_o && $past(sclO_o) && (sdaOeO_o != $past(sdaOeO_o))
        |-> phase inside {pStart, pStop});
    rspPulse: assert property (@(posedge clk) disable iff (rst)
        rspValid_o |=> !rspValid_o);

endmodule

//--- list.f
+incdir+common
common/imu_pkg.sv
i2c/i2c_byte_master.sv
hw/imu_regs.sv
hw/imu_sequencer.sv
hw/imu_top.sv
dv/mpu_model.sv
dv/tb_imu.sv
